// ==== rtl/pwrSeqPkg.sv ====
// One switchable domain only; settling time is a fixed cycle count and must fit the 5-bit timer
package pwrSeqPkg;

  // --------------------------------------------------------------------------
  // Sequencer states
  // --------------------------------------------------------------------------

  // Shutoff walks Init to PwrOff, restore walks PwrOn1 to RstClr
  typedef enum logic [3:0] {
    Init        = 4'd0,
    ClkOff      = 4'd1,
    Wait1       = 4'd2,
    Isolate     = 4'd3,
    SaveEdge    = 4'd4,
    PrePwrOff   = 4'd5,
    PwrOff      = 4'd6,
    PwrOn1      = 4'd7,
    PwrOn2      = 4'd8,
    RestoreEdge = 4'd9,
    Wait2       = 4'd10,
    DeIsolate   = 4'd11,
    ClkOn       = 4'd12,
    Wait3       = 4'd13,
    RstClr      = 4'd14
  } seqStateE;

  // --------------------------------------------------------------------------
  // Domain controls
  // --------------------------------------------------------------------------

  // All seven lines go to the switched domain and the power switches
  typedef struct packed {
    // High stops the domain clock
    logic gateClk;
    // High clamps the domain outputs
    logic isolate;
    // Active low reset of the non-retention logic
    logic rstnNonSrpg;
    // Power switch stage 1
    logic pwr1On;
    // Power switch stage 2
    logic pwr2On;
    // One-cycle pulse, copy state into the shadow
    logic saveEdge;
    // One-cycle pulse, copy the shadow back
    logic restoreEdge;
  } pwrCtlS;

  // Cycles the power switches need before the state is restored
  localparam int unsigned settleCycles = 28;

endpackage

// ==== rtl/pwrRegPkg.sv ====
// Plain strobe register bus with no ready; reads are combinational and valid only while rdEn is high
package pwrRegPkg;

  // --------------------------------------------------------------------------
  // Register map
  // --------------------------------------------------------------------------

  // Low-power request, read/write
  localparam logic [1:0] ctrlAddr = 2'd0;

  // Low-power status, read only
  localparam logic [1:0] statusAddr = 2'd1;

  // Domain word as seen through the isolation clamp, read only
  localparam logic [1:0] dataAddr = 2'd2;

  // Request bit in CTRL, status bit in STATUS
  localparam int unsigned reqBit = 0;

  // --------------------------------------------------------------------------
  // Bus request
  // --------------------------------------------------------------------------

  // One cycle of wrEn writes wdata to addr
  // One cycle of rdEn selects addr for the read mux
  typedef struct packed {
    logic       wrEn;
    logic       rdEn;
    logic [1:0] addr;
    logic [7:0] wdata;
  } regReqS;

endpackage

// ==== rtl/pwrRegFile.sv ====
// STATUS ignores bus writes and is owned by the sequencer; unmapped address 3 reads as zero
module pwrRegFile
(
  input  logic                pclk23,
  input  logic                nprst23,
  input  pwrRegPkg::regReqS   regReq,
  input  logic                setStatus,
  input  logic                clrStatus,
  input  logic [7:0]          domainData,
  output logic [7:0]          regRdata,
  output logic                l1Req
);

  // Request and status flops
  logic ctrlQ;
  logic statusQ;

  // Write decode for CTRL
  logic ctrlWr;

  assign ctrlWr = regReq.wrEn && (regReq.addr == pwrRegPkg::ctrlAddr);

  // --------------------------------------------------------------------------
  // CTRL register
  // --------------------------------------------------------------------------

  always_ff @(posedge pclk23 or negedge nprst23)
  begin
    if (!nprst23)
    begin
      ctrlQ <= 1'b0;
    end
    else if (ctrlWr)
    begin
      // Only the request bit is stored
      ctrlQ <= regReq.wdata[pwrRegPkg::reqBit];
    end
  end

  // Level request straight into the sequencer
  assign l1Req = ctrlQ;

  // --------------------------------------------------------------------------
  // STATUS register
  // --------------------------------------------------------------------------

  // Set has priority, though the sequencer never raises both
  always_ff @(posedge pclk23 or negedge nprst23)
  begin
    if (!nprst23)
    begin
      statusQ <= 1'b0;
    end
    else if (setStatus)
    begin
      statusQ <= 1'b1;
    end
    else if (clrStatus)
    begin
      statusQ <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Read mux
  // --------------------------------------------------------------------------

  always_comb
  begin
    regRdata = '0;
    if (regReq.rdEn)
    begin
      case (regReq.addr)
        pwrRegPkg::ctrlAddr:
        begin
          regRdata[pwrRegPkg::reqBit] = ctrlQ;
        end
        pwrRegPkg::statusAddr:
        begin
          regRdata[pwrRegPkg::reqBit] = statusQ;
        end
        pwrRegPkg::dataAddr:
        begin
          // Clamped value, so zero while isolated
          regRdata = domainData;
        end
        default:
        begin
          regRdata = '0;
        end
      endcase
    end
  end

endmodule

// ==== rtl/pwrSeqFsm.sv ====
// Fixed shutoff order; request changes are only sampled in Init and PwrOff, so a short pulse is missed
module pwrSeqFsm
(
  input  logic              pclk23,
  input  logic              nprst23,
  input  logic              l1Req,
  input  logic              settleDone,
  output logic              setStatus,
  output logic              clrStatus,
  output logic              settleStart,
  output pwrSeqPkg::pwrCtlS pwrCtl
);

  // State register and next state
  pwrSeqPkg::seqStateE curState;
  pwrSeqPkg::seqStateE nextState;

  // Registered controls, rstnNonSrpg not yet combined with reset
  pwrSeqPkg::pwrCtlS ctlQ;

  // Controls as decoded from the next state
  pwrSeqPkg::pwrCtlS ctlNext;

  // Map one state to the control levels it holds
  function automatic pwrSeqPkg::pwrCtlS decodeCtl(input pwrSeqPkg::seqStateE st);
    pwrSeqPkg::pwrCtlS ctl;
    // Clock runs only around the idle state
    ctl.gateClk = !(st inside {pwrSeqPkg::ClkOn, pwrSeqPkg::Wait3,
                               pwrSeqPkg::RstClr, pwrSeqPkg::Init});
    // Clamp from Isolate until the restore settles
    ctl.isolate = st inside {pwrSeqPkg::Isolate, pwrSeqPkg::SaveEdge,
                             pwrSeqPkg::PrePwrOff, pwrSeqPkg::PwrOff,
                             pwrSeqPkg::PwrOn1, pwrSeqPkg::PwrOn2,
                             pwrSeqPkg::RestoreEdge, pwrSeqPkg::Wait2};
    // Non-retention reset held from power-off until RstClr
    ctl.rstnNonSrpg = st inside {pwrSeqPkg::Init, pwrSeqPkg::ClkOff,
                                 pwrSeqPkg::Wait1, pwrSeqPkg::Isolate,
                                 pwrSeqPkg::SaveEdge, pwrSeqPkg::PrePwrOff,
                                 pwrSeqPkg::RstClr};
    // Stage 1 returns first, stage 2 one state later
    ctl.pwr1On = (st != pwrSeqPkg::PwrOff);
    ctl.pwr2On = !(st inside {pwrSeqPkg::PwrOff, pwrSeqPkg::PwrOn1});
    ctl.saveEdge = (st == pwrSeqPkg::SaveEdge);
    ctl.restoreEdge = (st == pwrSeqPkg::RestoreEdge);
    return ctl;
  endfunction

  // --------------------------------------------------------------------------
  // Next-state logic
  // --------------------------------------------------------------------------

  always_comb
  begin
    // Most states step on after one cycle
    nextState = curState;
    case (curState)
      pwrSeqPkg::Init:
      begin
        // Start shutoff once software asks for it
        if (l1Req)
        begin
          nextState = pwrSeqPkg::ClkOff;
        end
      end
      pwrSeqPkg::ClkOff:      nextState = pwrSeqPkg::Wait1;
      // Let the gated clock take effect
      pwrSeqPkg::Wait1:       nextState = pwrSeqPkg::Isolate;
      pwrSeqPkg::Isolate:     nextState = pwrSeqPkg::SaveEdge;
      pwrSeqPkg::SaveEdge:    nextState = pwrSeqPkg::PrePwrOff;
      pwrSeqPkg::PrePwrOff:   nextState = pwrSeqPkg::PwrOff;
      pwrSeqPkg::PwrOff:
      begin
        // Stay off until the request is withdrawn
        if (!l1Req)
        begin
          nextState = pwrSeqPkg::PwrOn1;
        end
      end
      pwrSeqPkg::PwrOn1:      nextState = pwrSeqPkg::PwrOn2;
      pwrSeqPkg::PwrOn2:
      begin
        // Supply must settle before state comes back
        if (settleDone)
        begin
          nextState = pwrSeqPkg::RestoreEdge;
        end
      end
      pwrSeqPkg::RestoreEdge: nextState = pwrSeqPkg::Wait2;
      pwrSeqPkg::Wait2:       nextState = pwrSeqPkg::DeIsolate;
      pwrSeqPkg::DeIsolate:   nextState = pwrSeqPkg::ClkOn;
      pwrSeqPkg::ClkOn:       nextState = pwrSeqPkg::Wait3;
      pwrSeqPkg::Wait3:       nextState = pwrSeqPkg::RstClr;
      pwrSeqPkg::RstClr:      nextState = pwrSeqPkg::Init;
      default:                nextState = pwrSeqPkg::Init;
    endcase
  end

  // --------------------------------------------------------------------------
  // State and control registers
  // --------------------------------------------------------------------------

  always_ff @(posedge pclk23 or negedge nprst23)
  begin
    if (!nprst23)
    begin
      curState <= pwrSeqPkg::Init;
    end
    else
    begin
      curState <= nextState;
    end
  end

  assign ctlNext = decodeCtl(nextState);

  // Each control is a flop fed from the next-state decode
  always_ff @(posedge pclk23 or negedge nprst23)
  begin
    if (!nprst23)
    begin
      ctlQ.gateClk     <= 1'b0;
      ctlQ.isolate     <= 1'b0;
      ctlQ.rstnNonSrpg <= 1'b0;
      // Domain powered out of reset
      ctlQ.pwr1On      <= 1'b1;
      ctlQ.pwr2On      <= 1'b1;
      ctlQ.saveEdge    <= 1'b0;
      ctlQ.restoreEdge <= 1'b0;
    end
    else
    begin
      ctlQ <= ctlNext;
    end
  end

  // Non-retention reset also follows the system reset
  always_comb
  begin
    pwrCtl = ctlQ;
    pwrCtl.rstnNonSrpg = ctlQ.rstnNonSrpg & nprst23;
  end

  // Status handshake and timer kick
  assign setStatus   = (nextState == pwrSeqPkg::ClkOff);
  assign clrStatus   = (curState == pwrSeqPkg::RstClr);
  assign settleStart = (curState == pwrSeqPkg::PwrOn1) && (nextState == pwrSeqPkg::PwrOn2);

endmodule

// ==== rtl/pwrSettleTimer.sv ====
// A start pulse while already counting is ignored; the count wraps back to zero one edge after done
module pwrSettleTimer
(
  input  logic pclk23,
  input  logic nprst23,
  input  logic settleStart,
  output logic settleDone
);

  // Terminal count at counter width
  localparam logic [4:0] doneCount = 5'(pwrSeqPkg::settleCycles);

  // Settling counter, zero when idle
  logic [4:0] cnt;

  // --------------------------------------------------------------------------
  // Counter
  // --------------------------------------------------------------------------

  always_ff @(posedge pclk23 or negedge nprst23)
  begin
    if (!nprst23)
    begin
      cnt <= '0;
    end
    else if (settleDone)
    begin
      // Back to idle so the next power-up gets a full period
      cnt <= '0;
    end
    else if ((cnt != '0) || settleStart)
    begin
      cnt <= cnt + 5'd1;
    end
  end

  // High for exactly one cycle per start
  assign settleDone = (cnt == doneCount);

endmodule

// ==== rtl/pwrRetainDomain.sv ====
// Behavioral domain model; the shadow word survives power-off, writes while clock gated are dropped
module pwrRetainDomain
(
  input  logic              pclk23,
  input  logic              nprst23,
  input  pwrSeqPkg::pwrCtlS pwrCtl,
  input  logic              domainWrEn,
  input  logic [7:0]        domainWData,
  output logic [7:0]        domainData
);

  // Working register, lost when the domain is off
  logic [7:0] dataQ;

  // Retention shadow
  logic [7:0] shadowQ;

  // Restore seen but reset still held
  logic restorePend;

  // Combined reset of the non-retention logic
  logic domRstN;

  assign domRstN = nprst23 & pwrCtl.rstnNonSrpg;

  // --------------------------------------------------------------------------
  // Retention side, powered throughout
  // --------------------------------------------------------------------------

  always_ff @(posedge pclk23 or negedge nprst23)
  begin
    if (!nprst23)
    begin
      shadowQ     <= '0;
      restorePend <= 1'b0;
    end
    else
    begin
      // Capture on the save pulse
      if (pwrCtl.saveEdge)
      begin
        shadowQ <= dataQ;
      end
      // Restore arms the load, which lands once the reset lifts
      if (pwrCtl.restoreEdge)
      begin
        restorePend <= 1'b1;
      end
      else if (domRstN)
      begin
        restorePend <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Switched side
  // --------------------------------------------------------------------------

  always_ff @(posedge pclk23 or negedge domRstN)
  begin
    if (!domRstN)
    begin
      dataQ <= '0;
    end
    else if (restorePend)
    begin
      dataQ <= shadowQ;
    end
    else if (domainWrEn && !pwrCtl.gateClk)
    begin
      // No clock, no update
      dataQ <= domainWData;
    end
  end

  // Output clamp to zero while isolated
  assign domainData = pwrCtl.isolate ? 8'h00 : dataQ;

endmodule

// ==== rtl/pwrCtrlTop.sv ====
// Single domain, single clock; pwrCtl is exported unchanged for the external power switches
module pwrCtrlTop
(
  input  logic              pclk23,
  input  logic              nprst23,
  input  pwrRegPkg::regReqS regReq,
  input  logic              domainWrEn,
  input  logic [7:0]        domainWData,
  output logic [7:0]        regRdata,
  output logic [7:0]        domainData,
  output pwrSeqPkg::pwrCtlS pwrCtl
);

  // Register file to sequencer
  logic l1Req;
  logic setStatus;
  logic clrStatus;

  // Sequencer to settling timer
  logic settleStart;
  logic settleDone;

  // --------------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------------

  pwrRegFile uRegFile
  (
    .pclk23     (pclk23),
    .nprst23    (nprst23),
    .regReq     (regReq),
    .setStatus  (setStatus),
    .clrStatus  (clrStatus),
    .domainData (domainData),
    .regRdata   (regRdata),
    .l1Req      (l1Req)
  );

  // --------------------------------------------------------------------------
  // Sequencer and timer
  // --------------------------------------------------------------------------

  pwrSeqFsm uSeqFsm
  (
    .pclk23      (pclk23),
    .nprst23     (nprst23),
    .l1Req       (l1Req),
    .settleDone  (settleDone),
    .setStatus   (setStatus),
    .clrStatus   (clrStatus),
    .settleStart (settleStart),
    .pwrCtl      (pwrCtl)
  );

  pwrSettleTimer uSettleTimer
  (
    .pclk23      (pclk23),
    .nprst23     (nprst23),
    .settleStart (settleStart),
    .settleDone  (settleDone)
  );

  // Switched domain
  pwrRetainDomain uDomain
  (
    .pclk23      (pclk23),
    .nprst23     (nprst23),
    .pwrCtl      (pwrCtl),
    .domainWrEn  (domainWrEn),
    .domainWData (domainWData),
    .domainData  (domainData)
  );

endmodule

// ==== testbench/pwrCtrl_props.sv ====
// Checks sequencer output ordering only; needs assertions enabled in the simulator to take effect
module pwrCtrlProps
(
  input logic              pclk23,
  input logic              nprst23,
  input logic              setStatus,
  input logic              clrStatus,
  input pwrSeqPkg::pwrCtlS pwrCtl
);

  timeunit 1ns;
  timeprecision 100ps;

  // --------------------------------------------------------------------------
  // Status handshake
  // --------------------------------------------------------------------------

  // Set and clear belong to opposite ends of the sequence
  noSetClr: assert property (@(posedge pclk23) disable iff (!nprst23)
    !(setStatus && clrStatus))
    else $error("STATUS set and clear asserted together");

  // --------------------------------------------------------------------------
  // Shutoff and restore order
  // --------------------------------------------------------------------------

  // ClkOff then Wait1 then Isolate
  gateThenIsolate: assert property (@(posedge pclk23) disable iff (!nprst23)
    $rose(pwrCtl.gateClk) |-> ##2 $rose(pwrCtl.isolate))
    else $error("isolate did not rise two cycles after gateClk");

  // Both switch stages cut together
  switchesOffTogether: assert property (@(posedge pclk23) disable iff (!nprst23)
    $fell(pwrCtl.pwr1On) |-> $fell(pwrCtl.pwr2On))
    else $error("pwr1On fell without pwr2On");

  // Stage 2 follows stage 1 by one cycle
  stagedPowerUp: assert property (@(posedge pclk23) disable iff (!nprst23)
    $rose(pwrCtl.pwr1On) |=> pwrCtl.pwr2On)
    else $error("pwr2On not high one cycle after pwr1On rose");

  saveWhileIsolated: assert property (@(posedge pclk23) disable iff (!nprst23)
    pwrCtl.saveEdge |-> pwrCtl.isolate)
    else $error("saveEdge high while outputs not isolated");

endmodule

bind pwrSeqFsm pwrCtrlProps uProps
(
  .pclk23    (pclk23),
  .nprst23   (nprst23),
  .setStatus (setStatus),
  .clrStatus (clrStatus),
  .pwrCtl    (pwrCtl)
);

// ==== testbench/pwrCtrlTb.sv ====
// Runs one full off/on cycle per table row and stops at the first mismatch; waits are cycle bounded
module pwrCtrlTb;

  timeunit 1ns;
  timeprecision 100ps;

  // Rows in the stimulus table
  localparam int numRows = 5;

  // Cycle bounds for the waits, with margin over the fixed sequence
  localparam int entryLimit = 12;
  localparam int restoreLimit = int'(pwrSeqPkg::settleCycles) + 24;

  // One off/on cycle
  typedef struct packed {
    logic [7:0] word;
    // Draw the word from $urandom instead
    logic       randWord;
    // Try a domain write while powered off
    logic       offWrite;
  } rowS;

  localparam rowS rows [numRows] = '{
    '{word: 8'hA5, randWord: 1'b0, offWrite: 1'b0},
    '{word: 8'h3C, randWord: 1'b0, offWrite: 1'b1},
    '{word: 8'h00, randWord: 1'b1, offWrite: 1'b0},
    '{word: 8'h00, randWord: 1'b1, offWrite: 1'b1},
    '{word: 8'hFF, randWord: 1'b0, offWrite: 1'b1}
  };

  string rowNames [numRows];

  // DUT ports
  logic              pclk23;
  logic              nprst23;
  pwrRegPkg::regReqS regReq;
  logic              domainWrEn;
  logic [7:0]        domainWData;
  logic [7:0]        regRdata;
  logic [7:0]        domainData;
  pwrSeqPkg::pwrCtlS pwrCtl;

  // Control levels expected while the domain is up and idle
  pwrSeqPkg::pwrCtlS idleCtl;

  // 100 ns period
  always #50 pclk23 = ~pclk23;

  pwrCtrlTop dut
  (
    .pclk23      (pclk23),
    .nprst23     (nprst23),
    .regReq      (regReq),
    .domainWrEn  (domainWrEn),
    .domainWData (domainWData),
    .regRdata    (regRdata),
    .domainData  (domainData),
    .pwrCtl      (pwrCtl)
  );

  // --------------------------------------------------------------------------
  // Reporting
  // --------------------------------------------------------------------------

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkEq(input string name, input logic [7:0] expected,
                         input logic [7:0] actual);
    if (actual !== expected)
    begin
      abortRun($sformatf("FAILED %s: expected 0x%02h, actual 0x%02h", name, expected, actual));
    end
  endtask

  // --------------------------------------------------------------------------
  // Bus and domain access
  // --------------------------------------------------------------------------

  // Write is taken on the second edge
  task automatic writeReg(input logic [1:0] addr, input logic [7:0] data);
    pwrRegPkg::regReqS req;
    req = '0;
    req.wrEn = 1'b1;
    req.addr = addr;
    req.wdata = data;
    @(posedge pclk23);
    regReq <= req;
    @(posedge pclk23);
    regReq <= '0;
  endtask

  // Read data is combinational, so sample mid-cycle
  task automatic readReg(input logic [1:0] addr, output logic [7:0] data);
    pwrRegPkg::regReqS req;
    req = '0;
    req.rdEn = 1'b1;
    req.addr = addr;
    @(posedge pclk23);
    regReq <= req;
    @(negedge pclk23);
    data = regRdata;
  endtask

  task automatic writeDomain(input logic [7:0] data);
    @(posedge pclk23);
    domainWrEn <= 1'b1;
    domainWData <= data;
    @(posedge pclk23);
    domainWrEn <= 1'b0;
  endtask

  // Poll STATUS until it shows the wanted level
  task automatic waitStatus(input logic expected, input int limit, input string what);
    logic [7:0] rd;
    logic       seen;
    int         cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && (cycles < limit))
    begin
      readReg(pwrRegPkg::statusAddr, rd);
      seen = (rd[pwrRegPkg::reqBit] == expected);
      cycles++;
    end
    if (!seen)
    begin
      abortRun($sformatf("Timeout: STATUS never read %0d %s", expected, what));
    end
  endtask

  task automatic waitPowerOff(input int limit, input string what);
    logic seen;
    int   cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && (cycles < limit))
    begin
      @(negedge pclk23);
      seen = !pwrCtl.pwr1On;
      cycles++;
    end
    if (!seen)
    begin
      abortRun({"Timeout: power switch 1 never turned off in ", what});
    end
  endtask

  // --------------------------------------------------------------------------
  // One off/on cycle per row
  // --------------------------------------------------------------------------

  task automatic runCycle(input int idx);
    rowS        row;
    string      name;
    logic [7:0] word;
    logic [7:0] rd;
    row = rows[idx];
    name = rowNames[idx];
    word = row.randWord ? 8'($urandom()) : row.word;
    // Known word in the working register before shutoff
    writeDomain(word);
    readReg(pwrRegPkg::dataAddr, rd);
    checkEq({name, " DATA before entry"}, word, rd);
    // Request low power
    writeReg(pwrRegPkg::ctrlAddr, 8'(1 << pwrRegPkg::reqBit));
    waitStatus(1'b1, entryLimit, {"after request in ", name});
    waitPowerOff(entryLimit, name);
    checkEq({name, " pwr2On off"}, 8'h00, {7'b0, pwrCtl.pwr2On});
    checkEq({name, " isolate on"}, 8'h01, {7'b0, pwrCtl.isolate});
    checkEq({name, " domainData clamped"}, 8'h00, domainData);
    readReg(pwrRegPkg::dataAddr, rd);
    checkEq({name, " DATA while off"}, 8'h00, rd);
    // Must be dropped, the shadow keeps the old word
    if (row.offWrite)
    begin
      writeDomain(~word);
    end
    // Withdraw the request, full settle plus restore
    writeReg(pwrRegPkg::ctrlAddr, 8'h00);
    waitStatus(1'b0, restoreLimit, {"after release in ", name});
    checkEq({name, " controls after restore"}, {1'b0, idleCtl}, {1'b0, pwrCtl});
    checkEq({name, " domainData after restore"}, word, domainData);
    readReg(pwrRegPkg::dataAddr, rd);
    checkEq({name, " DATA after restore"}, word, rd);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial
  begin
    logic [7:0] rd;
    pclk23 = 1'b0;
    nprst23 = 1'b0;
    regReq = '0;
    domainWrEn = 1'b0;
    domainWData = 8'h00;
    // Seed the generator once for the whole run
    void'($urandom(70));
    rowNames = '{"fixedA5", "offWrite3C", "random", "randomOffWrite", "onesOffWrite"};
    // Powered, clock running, no clamp, reset released
    idleCtl = '0;
    idleCtl.rstnNonSrpg = 1'b1;
    idleCtl.pwr1On = 1'b1;
    idleCtl.pwr2On = 1'b1;
    repeat (4) @(posedge pclk23);
    nprst23 <= 1'b1;
    // Non-retention reset lifts one edge after release
    repeat (2) @(posedge pclk23);
    readReg(pwrRegPkg::ctrlAddr, rd);
    checkEq("reset CTRL", 8'h00, rd);
    readReg(pwrRegPkg::statusAddr, rd);
    checkEq("reset STATUS", 8'h00, rd);
    checkEq("reset controls", {1'b0, idleCtl}, {1'b0, pwrCtl});
    writeDomain(8'h5A);
    readReg(pwrRegPkg::dataAddr, rd);
    checkEq("reset DATA readback", 8'h5A, rd);
    for (int i = 0; i < numRows; i++)
    begin
      runCycle(i);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== all.f ====
rtl/pwrSeqPkg.sv
rtl/pwrRegPkg.sv
rtl/pwrRegFile.sv
rtl/pwrSeqFsm.sv
rtl/pwrSettleTimer.sv
rtl/pwrRetainDomain.sv
rtl/pwrCtrlTop.sv
testbench/pwrCtrl_props.sv
testbench/pwrCtrlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the power controller testbench with Verilator; exits nonzero on failure

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module pwrCtrlTb -f all.f \
  || { echo "Build failed"; exit 1; }

simOut="$(./obj_dir/VpwrCtrlTb 2>&1)"
echo "$simOut"

grep -qxF '>>> PASS' <<< "$simOut" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
